// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cpu6_maindec
FLIST     = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
source/cpu6_pkg.sv
source/cpu6_instr_class.sv
source/cpu6_control_table.sv
source/cpu6_decode_reg.sv
source/cpu6_maindec.sv
tb/cpu6_maindec_chk.sv
tb/tb_cpu6_maindec.sv

// ==== source/cpu6_control_table.sv ====
`timescale 1ns/100ps

module cpu6_control_table import cpu6_pkg::*; (
   input  instr_kind_e kind,                     // from the classifier
   output logic        lui,
   output logic        auipc,
   output logic        mret,
   output logic        csr,                      // csr access enable
   output csr_src_e    csr_src,                  // rs1 or zimm operand
   output csr_wsc_e    csr_wsc,                  // write, set or clear
   output logic        memtoreg,
   output logic        memwrite,
   output branchtype_e branchtype,
   output alusrc_e     alusrc,
   output logic        regwrite,
   output logic        jump,
   output aluop_e      aluop,
   output immtype_e    immtype,
   output logic        illinstr
);

   always_comb begin
      // quiet word first, each kind only sets what differs
      lui        = 1'b0;
      auipc      = 1'b0;
      mret       = 1'b0;
      csr        = 1'b0;
      csr_src    = csr_src_rs1;
      csr_wsc    = wsc_w;
      memtoreg   = 1'b0;
      memwrite   = 1'b0;
      branchtype = bt_nobranch;
      alusrc     = alusrc_imm;
      regwrite   = 1'b0;
      jump       = 1'b0;
      aluop      = aluop_lwswjalr;
      immtype    = imm_i;
      illinstr   = 1'b0;

      case (kind)
         kind_lw: begin
            memtoreg = 1'b1;                     // rd from memory
            regwrite = 1'b1;
         end
         kind_sw: begin
            memwrite = 1'b1;
            immtype  = imm_s;                    // split immediate
         end
         kind_addi, kind_andi: begin
            regwrite = 1'b1;
            aluop    = aluop_arith;
         end
         kind_add, kind_sub, kind_and: begin
            regwrite = 1'b1;
            alusrc   = alusrc_rs2;               // second operand from regfile
            aluop    = aluop_arith;
            immtype  = imm_r;
         end
         kind_beq, kind_bne: begin
            branchtype = (kind == kind_beq) ? bt_beq : bt_bne;
            alusrc     = alusrc_rs2;
            aluop      = aluop_branch;           // alu does the compare
            immtype    = imm_b;
         end
         kind_jalr: begin
            regwrite = 1'b1;                     // link address to rd
            jump     = 1'b1;
         end
         kind_lui, kind_auipc: begin
            lui      = (kind == kind_lui);
            auipc    = (kind == kind_auipc);
            regwrite = 1'b1;
            immtype  = imm_u;                    // upper 20 bits
         end
         kind_csrrw, kind_csrrs, kind_csrrc,
         kind_csrrwi, kind_csrrsi, kind_csrrci: begin
            csr      = 1'b1;
            regwrite = 1'b1;                     // old csr value to rd
            if (kind == kind_csrrs || kind == kind_csrrsi)
               csr_wsc = wsc_s;
            else if (kind == kind_csrrc || kind == kind_csrrci)
               csr_wsc = wsc_c;
            if (kind inside {kind_csrrwi, kind_csrrsi, kind_csrrci})
               csr_src = csr_src_uimm;           // immediate forms
         end
         kind_mret: begin
            mret = 1'b1;                         // trap return only
         end
         default: begin
            illinstr = 1'b1;                     // everything else stays quiet
         end
      endcase
   end

endmodule

// ==== source/cpu6_decode_reg.sv ====
`timescale 1ns/100ps

module cpu6_decode_reg import cpu6_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,                    // sync, active low
   input  logic        instr_valid,              // one-cycle strobe
   input  logic        flush,                    // kill the stage
   input  logic        tbl_lui,                  // unregistered table fields
   input  logic        tbl_auipc,
   input  logic        tbl_mret,
   input  logic        tbl_csr,
   input  csr_src_e    tbl_csr_src,
   input  csr_wsc_e    tbl_csr_wsc,
   input  logic        tbl_memtoreg,
   input  logic        tbl_memwrite,
   input  branchtype_e tbl_branchtype,
   input  alusrc_e     tbl_alusrc,
   input  logic        tbl_regwrite,
   input  logic        tbl_jump,
   input  aluop_e      tbl_aluop,
   input  immtype_e    tbl_immtype,
   input  logic        tbl_illinstr,
   output logic        out_valid,                // high one cycle after strobe
   output logic        lui,
   output logic        auipc,
   output logic        mret,
   output logic        csr,
   output csr_src_e    csr_src,
   output csr_wsc_e    csr_wsc,
   output logic        memtoreg,
   output logic        memwrite,
   output branchtype_e branchtype,
   output alusrc_e     alusrc,
   output logic        regwrite,
   output logic        jump,
   output aluop_e      aluop,
   output immtype_e    immtype,
   output logic        illinstr
);

   always_ff @(posedge clk) begin
      if (!rst_n || flush) begin                 // reset and flush share the quiet word
         out_valid  <= 1'b0;
         lui        <= 1'b0;
         auipc      <= 1'b0;
         mret       <= 1'b0;
         csr        <= 1'b0;
         csr_src    <= csr_src_rs1;
         csr_wsc    <= wsc_w;
         memtoreg   <= 1'b0;
         memwrite   <= 1'b0;
         branchtype <= bt_nobranch;              // not zero, see pkg
         alusrc     <= alusrc_imm;
         regwrite   <= 1'b0;
         jump       <= 1'b0;
         aluop      <= aluop_lwswjalr;
         immtype    <= imm_i;
         illinstr   <= 1'b0;
      end else begin
         out_valid <= instr_valid;               // drops when no strobe
         if (instr_valid) begin                  // otherwise fields hold
            lui        <= tbl_lui;
            auipc      <= tbl_auipc;
            mret       <= tbl_mret;
            csr        <= tbl_csr;
            csr_src    <= tbl_csr_src;
            csr_wsc    <= tbl_csr_wsc;
            memtoreg   <= tbl_memtoreg;
            memwrite   <= tbl_memwrite;
            branchtype <= tbl_branchtype;
            alusrc     <= tbl_alusrc;
            regwrite   <= tbl_regwrite;
            jump       <= tbl_jump;
            aluop      <= tbl_aluop;
            immtype    <= tbl_immtype;
            illinstr   <= tbl_illinstr;
         end
      end
   end

endmodule

// ==== source/cpu6_instr_class.sv ====
`timescale 1ns/100ps

module cpu6_instr_class import cpu6_pkg::*; #(
   parameter bit CSR_EN = 1'b1                   // 0: system opcode is illegal
) (
   input  logic [XLEN-1:0] instr,                // raw instruction word
   output instr_kind_e     kind                  // one of nineteen, or illegal
);

   logic [OPCODE_W-1:0] opcode;                  // bits 6..0
   logic [FUNCT3_W-1:0] funct3;                  // bits 14..12
   logic [FUNCT7_W-1:0] funct7;                  // bits 31..25

   assign opcode = instr[OPCODE_W-1:0];
   assign funct3 = instr[12 +: FUNCT3_W];
   assign funct7 = instr[XLEN-1 -: FUNCT7_W];

   always_comb begin
      kind = kind_illegal;                       // default for unmatched words
      case (opcode)
         opc_load: begin
            if (funct3 == 3'b010)
               kind = kind_lw;                   // lb, lh, lbu, lhu not supported
         end
         opc_store: begin
            if (funct3 == 3'b010)
               kind = kind_sw;                   // word stores only
         end
         opc_lui:   kind = kind_lui;
         opc_auipc: kind = kind_auipc;
         opc_op_imm: begin
            case (funct3)
               3'b000:  kind = kind_addi;
               3'b111:  kind = kind_andi;
               default: kind = kind_illegal;     // slti, xori, shifts...
            endcase
         end
         opc_op: begin
            if (funct3 == 3'b000 && funct7 == F7_BASE)
               kind = kind_add;
            else if (funct3 == 3'b000 && funct7 == F7_SUB)
               kind = kind_sub;
            else if (funct3 == 3'b111 && funct7 == F7_BASE)
               kind = kind_and;
         end
         opc_branch: begin
            case (funct3)
               3'b000:  kind = kind_beq;
               3'b001:  kind = kind_bne;
               default: kind = kind_illegal;     // blt/bge family not supported
            endcase
         end
         opc_jalr: begin
            if (funct3 == 3'b000)
               kind = kind_jalr;
         end
         opc_system: begin
            if (CSR_EN) begin                    // build without csr keeps illegal
               case (funct3)
                  3'b000: begin
                     if (funct7 == F7_MRET)
                        kind = kind_mret;        // rs2/rs1/rd ignored
                  end
                  3'b001:  kind = kind_csrrw;
                  3'b010:  kind = kind_csrrs;
                  3'b011:  kind = kind_csrrc;
                  3'b101:  kind = kind_csrrwi;
                  3'b110:  kind = kind_csrrsi;
                  3'b111:  kind = kind_csrrci;
                  default: kind = kind_illegal;  // funct3 100 reserved
               endcase
            end
         end
         default: kind = kind_illegal;
      endcase
   end

endmodule

// ==== source/cpu6_maindec.sv ====
`timescale 1ns/100ps

module cpu6_maindec import cpu6_pkg::*; #(
   parameter bit CSR_EN = 1'b1                   // 0 builds without csr/mret
) (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            instr_valid,
   input  logic [XLEN-1:0] instr,
   input  logic            flush,
   output logic            out_valid,
   output logic            lui,
   output logic            auipc,
   output logic            mret,
   output logic            csr,
   output csr_src_e        csr_src,
   output csr_wsc_e        csr_wsc,
   output logic            memtoreg,
   output logic            memwrite,
   output branchtype_e     branchtype,
   output alusrc_e         alusrc,
   output logic            regwrite,
   output logic            jump,
   output aluop_e          aluop,
   output immtype_e        immtype,
   output logic            illinstr
);

   instr_kind_e kind;                            // classifier to table

   // table outputs, before the stage register
   logic        tbl_lui;
   logic        tbl_auipc;
   logic        tbl_mret;
   logic        tbl_csr;
   csr_src_e    tbl_csr_src;
   csr_wsc_e    tbl_csr_wsc;
   logic        tbl_memtoreg;
   logic        tbl_memwrite;
   branchtype_e tbl_branchtype;
   alusrc_e     tbl_alusrc;
   logic        tbl_regwrite;
   logic        tbl_jump;
   aluop_e      tbl_aluop;
   immtype_e    tbl_immtype;
   logic        tbl_illinstr;

   cpu6_instr_class #(
      .CSR_EN (CSR_EN)
   ) class0 (
      .instr (instr),
      .kind  (kind)
   );

   cpu6_control_table table0 (
      .kind       (kind),
      .lui        (tbl_lui),        .auipc    (tbl_auipc),
      .mret       (tbl_mret),       .csr      (tbl_csr),
      .csr_src    (tbl_csr_src),    .csr_wsc  (tbl_csr_wsc),
      .memtoreg   (tbl_memtoreg),   .memwrite (tbl_memwrite),
      .branchtype (tbl_branchtype), .alusrc   (tbl_alusrc),
      .regwrite   (tbl_regwrite),   .jump     (tbl_jump),
      .aluop      (tbl_aluop),      .immtype  (tbl_immtype),
      .illinstr   (tbl_illinstr)
   );

   cpu6_decode_reg reg0 (
      .clk            (clk),            .rst_n        (rst_n),
      .instr_valid    (instr_valid),    .flush        (flush),
      .tbl_lui        (tbl_lui),        .tbl_auipc    (tbl_auipc),
      .tbl_mret       (tbl_mret),       .tbl_csr      (tbl_csr),
      .tbl_csr_src    (tbl_csr_src),    .tbl_csr_wsc  (tbl_csr_wsc),
      .tbl_memtoreg   (tbl_memtoreg),   .tbl_memwrite (tbl_memwrite),
      .tbl_branchtype (tbl_branchtype), .tbl_alusrc   (tbl_alusrc),
      .tbl_regwrite   (tbl_regwrite),   .tbl_jump     (tbl_jump),
      .tbl_aluop      (tbl_aluop),      .tbl_immtype  (tbl_immtype),
      .tbl_illinstr   (tbl_illinstr),
      .out_valid      (out_valid),
      .lui            (lui),            .auipc        (auipc),
      .mret           (mret),           .csr          (csr),
      .csr_src        (csr_src),        .csr_wsc      (csr_wsc),
      .memtoreg       (memtoreg),       .memwrite     (memwrite),
      .branchtype     (branchtype),     .alusrc       (alusrc),
      .regwrite       (regwrite),       .jump         (jump),
      .aluop          (aluop),          .immtype      (immtype),
      .illinstr       (illinstr)
   );

endmodule

// ==== source/cpu6_pkg.sv ====
package cpu6_pkg;

   localparam int XLEN     = 32;                 // instruction width
   localparam int OPCODE_W = 7;
   localparam int FUNCT3_W = 3;
   localparam int FUNCT7_W = 7;

   // funct7 patterns that the decoder cares about
   localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;   // add, and
   localparam logic [FUNCT7_W-1:0] F7_SUB  = 7'b0100000;   // sub
   localparam logic [FUNCT7_W-1:0] F7_MRET = 7'b0011000;   // mret

   typedef enum logic [OPCODE_W-1:0] {
      opc_load   = 7'b0000011,
      opc_store  = 7'b0100011,
      opc_op_imm = 7'b0010011,                   // addi, andi
      opc_op     = 7'b0110011,                   // add, sub, and
      opc_branch = 7'b1100011,
      opc_jalr   = 7'b1100111,
      opc_system = 7'b1110011,                   // csr forms and mret
      opc_lui    = 7'b0110111,
      opc_auipc  = 7'b0010111
   } opcode_e;

   typedef enum logic [2:0] {
      bt_beq      = 3'b000,
      bt_bne      = 3'b001,
      bt_nobranch = 3'b010                       // nonzero on purpose
   } branchtype_e;

   typedef enum logic [1:0] {
      aluop_lwswjalr = 2'b00,                    // plain address add
      aluop_branch   = 2'b01,                    // compare
      aluop_arith    = 2'b10                     // funct3/funct7 pick the op
   } aluop_e;

   typedef enum logic [2:0] {
      imm_r = 3'b000,                            // no immediate
      imm_i = 3'b001,
      imm_s = 3'b010,
      imm_b = 3'b011,
      imm_u = 3'b100
   } immtype_e;

   typedef enum logic [1:0] {
      wsc_w = 2'b01,                             // same as funct3[1:0]
      wsc_s = 2'b10,
      wsc_c = 2'b11
   } csr_wsc_e;

   typedef enum logic {
      alusrc_rs2 = 1'b0,
      alusrc_imm = 1'b1
   } alusrc_e;

   typedef enum logic {
      csr_src_rs1  = 1'b0,
      csr_src_uimm = 1'b1                        // rs1 field used as zimm
   } csr_src_e;

   typedef enum logic [4:0] {
      kind_illegal,
      kind_lw, kind_sw,
      kind_addi, kind_add, kind_sub, kind_andi, kind_and,
      kind_beq, kind_bne,
      kind_jalr,
      kind_lui, kind_auipc,
      kind_csrrw, kind_csrrs, kind_csrrc,
      kind_csrrwi, kind_csrrsi, kind_csrrci,
      kind_mret
   } instr_kind_e;

endpackage

// ==== tb/cpu6_maindec_chk.sv ====
`timescale 1ns/100ps

module cpu6_maindec_chk (
   input logic clk,
   input logic rst_n,
   input logic instr_valid,
   input logic flush,
   input logic out_valid,
   input logic illinstr,
   input logic regwrite,
   input logic memwrite,
   input logic jump
);

   // a result needs an unflushed strobe one cycle back
   valid_after_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid |-> $past(instr_valid && !flush))
      else $error("out_valid without an unflushed strobe one cycle before");

   illegal_is_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      illinstr |-> !(regwrite || memwrite || jump))   // nothing may commit
      else $error("illinstr together with regwrite, memwrite or jump");

   quiet_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> !out_valid)
      else $error("out_valid high in the cycle after reset release");

endmodule

bind cpu6_maindec cpu6_maindec_chk chk0 (
   .clk         (clk),
   .rst_n       (rst_n),
   .instr_valid (instr_valid),
   .flush       (flush),
   .out_valid   (out_valid),
   .illinstr    (illinstr),
   .regwrite    (regwrite),
   .memwrite    (memwrite),
   .jump        (jump)
);

// ==== tb/tb_cpu6_maindec.sv ====
`timescale 1ns/100ps

module tb_cpu6_maindec import cpu6_pkg::*; ();

   localparam int TIMEOUT = 20;                  // cycles allowed per wait

   logic            clk = 1'b0;
   logic            rst_n;
   logic            instr_valid;
   logic [XLEN-1:0] instr;
   logic            flush;
   logic            out_valid, lui, auipc, mret, csr, memtoreg, memwrite;
   logic            regwrite, jump, illinstr;
   csr_src_e        csr_src;
   csr_wsc_e        csr_wsc;
   branchtype_e     branchtype;
   alusrc_e         alusrc;
   aluop_e          aluop;
   immtype_e        immtype;

   // expected control word from the reference model
   logic            exp_lui, exp_auipc, exp_mret, exp_csr, exp_memtoreg;
   logic            exp_memwrite, exp_regwrite, exp_jump, exp_illinstr;
   csr_src_e        exp_csr_src;
   csr_wsc_e        exp_csr_wsc;
   branchtype_e     exp_branchtype;
   alusrc_e         exp_alusrc;
   aluop_e          exp_aluop;
   immtype_e        exp_immtype;

   int          errors = 0;
   int          checks = 0;
   int          tests  = 0;
   logic [31:0] rnd    = 32'd20;                 // xorshift state, seed

   instr_kind_e legal_kinds [19] = '{
      kind_lw, kind_sw, kind_addi, kind_add, kind_sub, kind_andi, kind_and,
      kind_beq, kind_bne, kind_jalr, kind_lui, kind_auipc,
      kind_csrrw, kind_csrrs, kind_csrrc, kind_csrrwi, kind_csrrsi, kind_csrrci,
      kind_mret
   };

   cpu6_maindec #(.CSR_EN(1'b1)) dut0 (.*);

   always #5 clk = ~clk;                         // 10 ns period

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // legal encoding of kind k, free fields taken from r
   function automatic logic [31:0] build_word(input instr_kind_e k, input logic [31:0] r);
      logic [31:0] w;
      w = r;
      case (k)
         kind_lw:     {w[14:12], w[6:0]} = {3'b010, 7'b0000011};
         kind_sw:     {w[14:12], w[6:0]} = {3'b010, 7'b0100011};
         kind_addi:   {w[14:12], w[6:0]} = {3'b000, 7'b0010011};
         kind_andi:   {w[14:12], w[6:0]} = {3'b111, 7'b0010011};
         kind_add:    w = {7'b0000000, r[24:15], 3'b000, r[11:7], 7'b0110011};
         kind_sub:    w = {7'b0100000, r[24:15], 3'b000, r[11:7], 7'b0110011};
         kind_and:    w = {7'b0000000, r[24:15], 3'b111, r[11:7], 7'b0110011};
         kind_beq:    {w[14:12], w[6:0]} = {3'b000, 7'b1100011};
         kind_bne:    {w[14:12], w[6:0]} = {3'b001, 7'b1100011};
         kind_jalr:   {w[14:12], w[6:0]} = {3'b000, 7'b1100111};
         kind_lui:    w[6:0] = 7'b0110111;
         kind_auipc:  w[6:0] = 7'b0010111;
         kind_csrrw:  {w[14:12], w[6:0]} = {3'b001, 7'b1110011};
         kind_csrrs:  {w[14:12], w[6:0]} = {3'b010, 7'b1110011};
         kind_csrrc:  {w[14:12], w[6:0]} = {3'b011, 7'b1110011};
         kind_csrrwi: {w[14:12], w[6:0]} = {3'b101, 7'b1110011};
         kind_csrrsi: {w[14:12], w[6:0]} = {3'b110, 7'b1110011};
         kind_csrrci: {w[14:12], w[6:0]} = {3'b111, 7'b1110011};
         kind_mret:   w = {7'b0011000, r[24:15], 3'b000, r[11:7], 7'b1110011};
         default:     w = 32'h0000_0000;         // opcode 0 never decodes
      endcase
      return w;
   endfunction

   function automatic bit known_opcode(input logic [6:0] op);
      return op inside {7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011, 7'b1100011,
                        7'b1100111, 7'b1110011, 7'b0110111, 7'b0010111};
   endfunction

   task automatic model_quiet();
      exp_lui        = 1'b0;
      exp_auipc      = 1'b0;
      exp_mret       = 1'b0;
      exp_csr        = 1'b0;
      exp_memtoreg   = 1'b0;
      exp_memwrite   = 1'b0;
      exp_regwrite   = 1'b0;
      exp_jump       = 1'b0;
      exp_illinstr   = 1'b0;
      exp_csr_src    = csr_src_rs1;
      exp_csr_wsc    = wsc_w;
      exp_branchtype = bt_nobranch;
      exp_alusrc     = alusrc_imm;
      exp_aluop      = aluop_lwswjalr;
      exp_immtype    = imm_i;
   endtask

   task automatic model_csr(input csr_wsc_e wsc, input csr_src_e src);
      exp_csr      = 1'b1;
      exp_regwrite = 1'b1;                       // old value to rd
      exp_csr_wsc  = wsc;
      exp_csr_src  = src;
   endtask

   task automatic model_control(input instr_kind_e k);
      model_quiet();                             // unnamed fields stay quiet
      case (k)
         kind_lw: begin
            exp_memtoreg = 1'b1;
            exp_regwrite = 1'b1;
         end
         kind_sw: begin
            exp_memwrite = 1'b1;
            exp_immtype  = imm_s;
         end
         kind_addi, kind_andi: begin
            exp_regwrite = 1'b1;
            exp_aluop    = aluop_arith;
         end
         kind_add, kind_sub, kind_and: begin
            exp_regwrite = 1'b1;
            exp_alusrc   = alusrc_rs2;
            exp_aluop    = aluop_arith;
            exp_immtype  = imm_r;
         end
         kind_beq, kind_bne: begin
            exp_branchtype = (k == kind_bne) ? bt_bne : bt_beq;
            exp_alusrc     = alusrc_rs2;
            exp_aluop      = aluop_branch;
            exp_immtype    = imm_b;
         end
         kind_jalr: begin
            exp_regwrite = 1'b1;
            exp_jump     = 1'b1;
         end
         kind_lui: begin
            exp_lui      = 1'b1;
            exp_regwrite = 1'b1;
            exp_immtype  = imm_u;
         end
         kind_auipc: begin
            exp_auipc    = 1'b1;
            exp_regwrite = 1'b1;
            exp_immtype  = imm_u;
         end
         kind_csrrw:  model_csr(wsc_w, csr_src_rs1);
         kind_csrrs:  model_csr(wsc_s, csr_src_rs1);
         kind_csrrc:  model_csr(wsc_c, csr_src_rs1);
         kind_csrrwi: model_csr(wsc_w, csr_src_uimm);
         kind_csrrsi: model_csr(wsc_s, csr_src_uimm);
         kind_csrrci: model_csr(wsc_c, csr_src_uimm);
         kind_mret:   exp_mret = 1'b1;
         default:     exp_illinstr = 1'b1;
      endcase
   endtask

   task automatic tally(input string name, input bit bad, input logic [31:0] got,
                        input logic [31:0] exp);
      checks++;
      if (bad) begin
         errors++;
         $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      tally(name, got !== exp, 32'(got), 32'(exp));
   endtask

   task automatic check_branchtype(input string name, input branchtype_e got,
                                   input branchtype_e exp);
      tally(name, got !== exp, 32'(got), 32'(exp));
   endtask

   task automatic check_aluop(input string name, input aluop_e got, input aluop_e exp);
      tally(name, got !== exp, 32'(got), 32'(exp));
   endtask

   task automatic check_immtype(input string name, input immtype_e got, input immtype_e exp);
      tally(name, got !== exp, 32'(got), 32'(exp));
   endtask

   task automatic check_csr_wsc(input string name, input csr_wsc_e got, input csr_wsc_e exp);
      tally(name, got !== exp, 32'(got), 32'(exp));
   endtask

   task automatic check_alusrc(input string name, input alusrc_e got, input alusrc_e exp);
      tally(name, got !== exp, 32'(got), 32'(exp));
   endtask

   task automatic check_csr_src(input string name, input csr_src_e got, input csr_src_e exp);
      tally(name, got !== exp, 32'(got), 32'(exp));
   endtask

   task automatic compare_fields();
      check_bit("lui", lui, exp_lui);
      check_bit("auipc", auipc, exp_auipc);
      check_bit("mret", mret, exp_mret);
      check_bit("csr", csr, exp_csr);
      check_bit("memtoreg", memtoreg, exp_memtoreg);
      check_bit("memwrite", memwrite, exp_memwrite);
      check_bit("regwrite", regwrite, exp_regwrite);
      check_bit("jump", jump, exp_jump);
      check_bit("illinstr", illinstr, exp_illinstr);
      check_csr_src("csr_src", csr_src, exp_csr_src);
      check_csr_wsc("csr_wsc", csr_wsc, exp_csr_wsc);
      check_branchtype("branchtype", branchtype, exp_branchtype);
      check_alusrc("alusrc", alusrc, exp_alusrc);
      check_aluop("aluop", aluop, exp_aluop);
      check_immtype("immtype", immtype, exp_immtype);
   endtask

   // single-cycle strobe, inputs change only on the rising edge
   task automatic strobe(input logic [XLEN-1:0] w, input logic fl);
      @(posedge clk);
      instr       <= w;
      instr_valid <= 1'b1;
      flush       <= fl;
      @(posedge clk);
      instr_valid <= 1'b0;
      flush       <= 1'b0;
   endtask

   task automatic wait_out_valid(output bit seen);
      int cnt;
      cnt  = 0;
      seen = 1'b0;
      while (!seen && cnt < TIMEOUT) begin
         @(negedge clk);                         // sample away from the edge
         cnt++;
         seen = (out_valid === 1'b1);
      end
      if (!seen) begin
         errors++;
         $display("timeout: out_valid did not rise within %0d cycles", TIMEOUT);
      end else if (cnt != 1) begin
         errors++;
         $display("out_valid came %0d cycles after the strobe instead of 1", cnt);
      end
   endtask

   task automatic decode_one(input instr_kind_e k, input logic [XLEN-1:0] w);
      bit seen;
      strobe(w, 1'b0);
      wait_out_valid(seen);
      if (seen) begin
         model_control(k);
         compare_fields();
      end
   endtask

   task automatic report_test(input string name, input int start);
      tests++;
      if (errors == start)
         $display("test %-14s ok", name);
      else
         $display("test %-14s %0d mismatches", name, errors - start);
   endtask

   task automatic test_reset();
      int start;
      start = errors;
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b0);
      model_quiet();
      compare_fields();                          // illinstr 0 is part of quiet word
      report_test("reset", start);
   endtask

   task automatic test_supported();
      int start;
      start = errors;
      foreach (legal_kinds[i]) begin
         repeat (3) begin
            rnd = xorshift32(rnd);
            decode_one(legal_kinds[i], build_word(legal_kinds[i], rnd));
         end
      end
      report_test("supported", start);
   endtask

   task automatic test_illegal();
      int          start;
      int          tries;
      logic [31:0] w;
      start = errors;
      rnd = xorshift32(rnd);
      w = build_word(kind_add, rnd);
      w[31:25] = 7'b0100001;                     // bad funct7 on add
      decode_one(kind_illegal, w);
      w = build_word(kind_beq, rnd);
      w[14:12] = 3'b100;                         // blt
      decode_one(kind_illegal, w);
      w = build_word(kind_addi, rnd);
      w[14:12] = 3'b001;                         // slli
      decode_one(kind_illegal, w);
      w = build_word(kind_jalr, rnd);
      w[14:12] = 3'b010;
      decode_one(kind_illegal, w);
      w = build_word(kind_lw, rnd);
      w[14:12] = 3'b000;                         // lb
      decode_one(kind_illegal, w);
      w = build_word(kind_sw, rnd);
      w[14:12] = 3'b001;                         // sh
      decode_one(kind_illegal, w);
      w = build_word(kind_csrrw, rnd);
      w[14:12] = 3'b100;                         // reserved system funct3
      decode_one(kind_illegal, w);
      decode_one(kind_illegal, 32'h3220_0073);   // mret with wrong funct7
      repeat (8) begin
         tries = 0;
         do begin
            rnd = xorshift32(rnd);
            tries++;
         end while (known_opcode(rnd[6:0]) && tries < 50);
         decode_one(kind_illegal, rnd);
      end
      report_test("illegal", start);
   endtask

   task automatic test_back_to_back();
      int              start;
      instr_kind_e     seq [6];
      logic [XLEN-1:0] words [6];
      start = errors;
      seq = '{kind_lw, kind_sub, kind_bne, kind_csrrsi, kind_lui, kind_mret};
      foreach (seq[i]) begin
         rnd = xorshift32(rnd);
         words[i] = build_word(seq[i], rnd);
      end
      @(posedge clk);
      instr       <= words[0];
      instr_valid <= 1'b1;
      for (int i = 1; i < 6; i++) begin
         @(posedge clk);
         instr <= words[i];                      // next strobe right behind
         @(negedge clk);
         check_bit("out_valid", out_valid, 1'b1);
         model_control(seq[i-1]);
         compare_fields();
      end
      @(posedge clk);
      instr_valid <= 1'b0;
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b1);
      model_control(seq[5]);
      compare_fields();
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b0);   // no strobe, valid drops
      compare_fields();                          // fields hold last decode
      report_test("back_to_back", start);
   endtask

   task automatic test_flush();
      int start;
      start = errors;
      rnd = xorshift32(rnd);
      decode_one(kind_lw, build_word(kind_lw, rnd));  // leave a non-quiet word
      rnd = xorshift32(rnd);
      @(posedge clk);
      instr       <= build_word(kind_sw, rnd);
      instr_valid <= 1'b1;
      flush       <= 1'b1;
      rnd = xorshift32(rnd);
      @(posedge clk);
      instr <= build_word(kind_add, rnd);        // strobe stays high, flush drops
      flush <= 1'b0;
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b0);
      model_quiet();
      compare_fields();
      @(posedge clk);
      instr_valid <= 1'b0;
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b1);
      model_control(kind_add);
      compare_fields();
      report_test("flush", start);
   endtask

   initial begin
      rst_n       = 1'b0;
      instr_valid = 1'b0;
      instr       = '0;
      flush       = 1'b0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;                             // released after 4 cycles
      test_reset();
      test_supported();
      test_illegal();
      test_back_to_back();
      test_flush();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule
